/* include/rvCore_params.svh */
`ifndef RVCORE_PARAMS_SVH
`define RVCORE_PARAMS_SVH

// --------------------------------------------------
// Core-wide sizes
// --------------------------------------------------

// Data and address width
`define RV_XLEN 32

// Integer register file
`define RV_REG_COUNT 32
`define RV_REG_IDX_W 5

// --------------------------------------------------
// Reset state
// --------------------------------------------------

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* design/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

    // --------------------------------------------------
    // Major opcodes, inst[6:0]
    // --------------------------------------------------
    typedef enum logic [6:0] {
        OPC_R     = 7'b0110011,
        OPC_I     = 7'b0010011,
        OPC_L     = 7'b0000011,
        OPC_S     = 7'b0100011,
        OPC_B     = 7'b1100011,
        OPC_JAL   = 7'b1101111,
        OPC_JALR  = 7'b1100111,
        OPC_LUI   = 7'b0110111,
        OPC_AUIPC = 7'b0010111
    } opcodeE;

    // --------------------------------------------------
    // funct3, inst[14:12]
    // --------------------------------------------------

    // Conditional branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Register and immediate arithmetic
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;   // SRL or SRA, split by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Word-sized load and store
    localparam logic [2:0] F3_LW_SW = 3'b010;

endpackage

`default_nettype wire

/* design/rvCtrlPkg.sv */
`default_nettype none

package rvCtrlPkg;

    // Operation class from the main decoder
    typedef enum logic [1:0] {
        ALUOP_MEM    = 2'b00,   // plain add, also for address math
        ALUOP_BRANCH = 2'b01,
        ALUOP_REG    = 2'b10,
        ALUOP_IMM    = 2'b11
    } aluOpE;

    // Function actually performed by the ALU
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } aluFuncE;

    // Operand A source
    typedef enum logic [1:0] {
        ASEL_REG  = 2'b00,
        ASEL_PC   = 2'b01,
        ASEL_ZERO = 2'b10
    } aSelE;

endpackage

`default_nettype wire

/* design/controller.sv */
`timescale 1ns/1ps
`default_nettype none

module controller (
    input  logic [31:0]        inst,
    output logic               branchEq,
    output logic               branchNe,
    output logic               branchLt,
    output logic               branchGe,
    output logic               jump,
    output logic               jumpReg,
    output rvCtrlPkg::aluOpE   aluOp,
    output logic               aluSrc,
    output rvCtrlPkg::aSelE    aSel,
    output logic               memRead,
    output logic               memWrite,
    output logic               memToReg,
    output logic               linkPc,
    output logic               regWrite
);

    rvIsaPkg::opcodeE opcode;
    logic [2:0]       funct3;
    logic             isR, isI, isL, isS, isB, isJal, isJalr, isLui, isAuipc;

    assign opcode = rvIsaPkg::opcodeE'(inst[6:0]);
    assign funct3 = inst[14:12];

    // --------------------------------------------------
    // Opcode classes
    // --------------------------------------------------
    assign isR     = (opcode == rvIsaPkg::OPC_R);
    assign isI     = (opcode == rvIsaPkg::OPC_I);
    // Word access only
    assign isL     = (opcode == rvIsaPkg::OPC_L) && (funct3 == rvIsaPkg::F3_LW_SW);
    assign isS     = (opcode == rvIsaPkg::OPC_S) && (funct3 == rvIsaPkg::F3_LW_SW);
    assign isB     = (opcode == rvIsaPkg::OPC_B);
    assign isJal   = (opcode == rvIsaPkg::OPC_JAL);
    assign isJalr  = (opcode == rvIsaPkg::OPC_JALR);
    assign isLui   = (opcode == rvIsaPkg::OPC_LUI);
    assign isAuipc = (opcode == rvIsaPkg::OPC_AUIPC);

    // Branch kinds, unsigned folded into lt/ge
    assign branchEq = isB && (funct3 == rvIsaPkg::F3_BEQ);
    assign branchNe = isB && (funct3 == rvIsaPkg::F3_BNE);
    assign branchLt = isB && (funct3 == rvIsaPkg::F3_BLT || funct3 == rvIsaPkg::F3_BLTU);
    assign branchGe = isB && (funct3 == rvIsaPkg::F3_BGE || funct3 == rvIsaPkg::F3_BGEU);

    assign jump    = isJal;
    assign jumpReg = isJalr;

    // --------------------------------------------------
    // ALU setup
    // --------------------------------------------------
    // Loads, stores, LUI, AUIPC and JALR all just add
    always_comb begin
        if (isR) begin
            aluOp = rvCtrlPkg::ALUOP_REG;
        end else if (isI) begin
            aluOp = rvCtrlPkg::ALUOP_IMM;
        end else if (isB) begin
            aluOp = rvCtrlPkg::ALUOP_BRANCH;
        end else begin
            aluOp = rvCtrlPkg::ALUOP_MEM;
        end
    end

    assign aluSrc = isI || isL || isS || isLui || isAuipc || isJalr;

    // LUI adds to zero, AUIPC adds to the PC
    assign aSel = isLui   ? rvCtrlPkg::ASEL_ZERO :
                  isAuipc ? rvCtrlPkg::ASEL_PC   : rvCtrlPkg::ASEL_REG;

    // Memory and write-back
    assign memRead  = isL;
    assign memWrite = isS;
    assign memToReg = isL;
    assign linkPc   = isJal || isJalr;
    assign regWrite = isR || isI || isL || isLui || isAuipc || isJal || isJalr;

endmodule

`default_nettype wire

/* design/aluControl.sv */
`timescale 1ns/1ps
`default_nettype none

module aluControl (
    input  rvCtrlPkg::aluOpE   aluOp,
    input  logic [2:0]         funct3,
    input  logic               funct7b5,
    output rvCtrlPkg::aluFuncE aluFunc
);

    always_comb begin
        aluFunc = rvCtrlPkg::ALU_ADD;
        unique case (aluOp)
            rvCtrlPkg::ALUOP_MEM: begin
                aluFunc = rvCtrlPkg::ALU_ADD;
            end
            // Compare mode for the branch unit
            rvCtrlPkg::ALUOP_BRANCH: begin
                case (funct3)
                    rvIsaPkg::F3_BEQ, rvIsaPkg::F3_BNE: aluFunc = rvCtrlPkg::ALU_SUB;
                    rvIsaPkg::F3_BLT, rvIsaPkg::F3_BGE: aluFunc = rvCtrlPkg::ALU_SLT;
                    default:                            aluFunc = rvCtrlPkg::ALU_SLTU;
                endcase
            end
            // REG and IMM share one table
            default: begin
                case (funct3)
                    // No SUBI, so bit 30 only counts for R-type
                    rvIsaPkg::F3_ADD: aluFunc = (aluOp == rvCtrlPkg::ALUOP_REG && funct7b5) ?
                                                rvCtrlPkg::ALU_SUB : rvCtrlPkg::ALU_ADD;
                    rvIsaPkg::F3_SLL:  aluFunc = rvCtrlPkg::ALU_SLL;
                    rvIsaPkg::F3_SLT:  aluFunc = rvCtrlPkg::ALU_SLT;
                    rvIsaPkg::F3_SLTU: aluFunc = rvCtrlPkg::ALU_SLTU;
                    rvIsaPkg::F3_XOR:  aluFunc = rvCtrlPkg::ALU_XOR;
                    // Shift right, arithmetic when bit 30 set
                    rvIsaPkg::F3_SR:   aluFunc = funct7b5 ? rvCtrlPkg::ALU_SRA :
                                                            rvCtrlPkg::ALU_SRL;
                    rvIsaPkg::F3_OR:   aluFunc = rvCtrlPkg::ALU_OR;
                    default:           aluFunc = rvCtrlPkg::ALU_AND;
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvCore_params.svh"

module alu (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  rvCtrlPkg::aluFuncE  aluFunc,
    output logic [`RV_XLEN-1:0] result,
    output logic                zero
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    // Only the low 5 bits shift
    assign shamt = b[4:0];

    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        unique case (aluFunc)
            rvCtrlPkg::ALU_ADD:  result = a + b;
            rvCtrlPkg::ALU_SUB:  result = a - b;
            rvCtrlPkg::ALU_AND:  result = a & b;
            rvCtrlPkg::ALU_OR:   result = a | b;
            rvCtrlPkg::ALU_XOR:  result = a ^ b;
            rvCtrlPkg::ALU_SLL:  result = a << shamt;
            rvCtrlPkg::ALU_SRL:  result = a >> shamt;
            // Sign fill from bit 31
            rvCtrlPkg::ALU_SRA:  result = $signed(a) >>> shamt;
            // Compares give 0 or 1, bit 0 feeds the branch unit
            rvCtrlPkg::ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, ltSigned};
            rvCtrlPkg::ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, ltUnsigned};
            default:             result = '0;
        endcase
    end

    // Equality flag for BEQ/BNE
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* design/regFile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvCore_params.svh"

module regFile (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [`RV_REG_IDX_W-1:0] rs1Addr,
    input  logic [`RV_REG_IDX_W-1:0] rs2Addr,
    input  logic [`RV_REG_IDX_W-1:0] rdAddr,
    input  logic                     rdWrite,
    input  logic [`RV_XLEN-1:0]      rdData,
    output logic [`RV_XLEN-1:0]      rs1Data,
    output logic [`RV_XLEN-1:0]      rs2Data
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // Write port, x0 never written so it reads zero forever
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWrite && (rdAddr != '0)) begin
            regs[rdAddr] <= rdData;
        end
    end

    // Asynchronous read ports
    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

endmodule

`default_nettype wire

/* design/immGen.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvCore_params.svh"

module immGen (
    input  logic [31:0]         inst,
    output logic [`RV_XLEN-1:0] imm
);

    rvIsaPkg::opcodeE opcode;

    assign opcode = rvIsaPkg::opcodeE'(inst[6:0]);

    // Format picked by opcode, sign always from inst[31]
    always_comb begin
        case (opcode)
            // I format
            rvIsaPkg::OPC_I, rvIsaPkg::OPC_L, rvIsaPkg::OPC_JALR: begin
                imm = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
            end
            // S format, split field
            rvIsaPkg::OPC_S: begin
                imm = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            end
            // B format, halfword offset
            rvIsaPkg::OPC_B: begin
                imm = {{(`RV_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            end
            // U format, upper 20 bits
            rvIsaPkg::OPC_LUI, rvIsaPkg::OPC_AUIPC: begin
                imm = {inst[31:12], 12'b0};
            end
            // J format
            rvIsaPkg::OPC_JAL: begin
                imm = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/pcUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvCore_params.svh"

module pcUnit (
    input  logic                clk,
    input  logic                rstN,
    input  logic                branchEq,
    input  logic                branchNe,
    input  logic                branchLt,
    input  logic                branchGe,
    input  logic                jump,
    input  logic                jumpReg,
    input  logic                zero,
    input  logic                ltBit,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic [`RV_XLEN-1:0] jumpRegTarget,
    output logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] pcPlus4
);

    logic                taken;
    logic [`RV_XLEN-1:0] nextPc;

    assign pcPlus4 = pc + `RV_XLEN'(4);

    // --------------------------------------------------
    // Branch decision
    // --------------------------------------------------
    // ALU in compare mode: zero for eq/ne, result[0] for lt/ge
    assign taken = (branchEq &&  zero)  ||
                   (branchNe && !zero)  ||
                   (branchLt &&  ltBit) ||
                   (branchGe && !ltBit);

    // --------------------------------------------------
    // Next PC
    // --------------------------------------------------
    always_comb begin
        if (jumpReg) begin
            // JALR clears bit 0 of rs1+imm
            nextPc = {jumpRegTarget[`RV_XLEN-1:1], 1'b0};
        end else if (jump || taken) begin
            nextPc = pc + imm;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

/* design/rvCore.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvCore_params.svh"

module rvCore (
    input  logic                clk,
    input  logic                rstN,
    input  logic [31:0]         inst,
    input  logic [`RV_XLEN-1:0] dataRData,
    output logic [`RV_XLEN-1:0] instAddr,
    output logic [`RV_XLEN-1:0] dataAddr,
    output logic [`RV_XLEN-1:0] dataWData,
    output logic                dataWrite,
    output logic                dataRead
);

    // Decoder levels
    logic branchEq, branchNe, branchLt, branchGe;
    logic jump, jumpReg, aluSrc, memRead, memWrite, memToReg, linkPc, regWrite;
    rvCtrlPkg::aluOpE   aluOp;
    rvCtrlPkg::aSelE    aSel;
    rvCtrlPkg::aluFuncE aluFunc;

    // Datapath
    logic [`RV_XLEN-1:0] pc, pcPlus4, imm;
    logic [`RV_XLEN-1:0] rs1Data, rs2Data;
    logic [`RV_XLEN-1:0] aluA, aluB, aluResult, wbData;
    logic                zero;

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    controller u_controller (
        .inst     (inst),
        .branchEq (branchEq),
        .branchNe (branchNe),
        .branchLt (branchLt),
        .branchGe (branchGe),
        .jump     (jump),
        .jumpReg  (jumpReg),
        .aluOp    (aluOp),
        .aluSrc   (aluSrc),
        .aSel     (aSel),
        .memRead  (memRead),
        .memWrite (memWrite),
        .memToReg (memToReg),
        .linkPc   (linkPc),
        .regWrite (regWrite)
    );

    // funct7 bit 5 is inst[30]
    aluControl u_aluControl (
        .aluOp    (aluOp),
        .funct3   (inst[14:12]),
        .funct7b5 (inst[30]),
        .aluFunc  (aluFunc)
    );

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    regFile u_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (inst[19:15]),
        .rs2Addr (inst[24:20]),
        .rdAddr  (inst[11:7]),
        .rdWrite (regWrite),
        .rdData  (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    immGen u_immGen (
        .inst (inst),
        .imm  (imm)
    );

    // Operand A: rs1, PC for AUIPC, zero for LUI
    always_comb begin
        case (aSel)
            rvCtrlPkg::ASEL_PC:   aluA = pc;
            rvCtrlPkg::ASEL_ZERO: aluA = '0;
            default:              aluA = rs1Data;
        endcase
    end

    assign aluB = aluSrc ? imm : rs2Data;

    alu u_alu (
        .a       (aluA),
        .b       (aluB),
        .aluFunc (aluFunc),
        .result  (aluResult),
        .zero    (zero)
    );

    // JALR target comes straight from rs1+imm
    pcUnit u_pcUnit (
        .clk           (clk),
        .rstN          (rstN),
        .branchEq      (branchEq),
        .branchNe      (branchNe),
        .branchLt      (branchLt),
        .branchGe      (branchGe),
        .jump          (jump),
        .jumpReg       (jumpReg),
        .zero          (zero),
        .ltBit         (aluResult[0]),
        .imm           (imm),
        .jumpRegTarget (aluResult),
        .pc            (pc),
        .pcPlus4       (pcPlus4)
    );

    // Write-back: load data, link address, else ALU
    assign wbData = memToReg ? dataRData :
                    linkPc   ? pcPlus4   : aluResult;

    // External ports
    assign instAddr  = pc;
    assign dataAddr  = aluResult;
    assign dataWData = rs2Data;
    assign dataWrite = memWrite;
    assign dataRead  = memRead;

endmodule

`default_nettype wire

/* dv/rvCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvCore_params.svh"

module rvCoreTb;

    // --------------------------------------------------
    // Run limit
    // --------------------------------------------------
    // Six programs with under 300 instructions in all
    // Plus 4 reset cycles each and a wide margin
    localparam int CYCLE_LIMIT = 2000;

    logic                clk;
    logic                rstN;
    logic [31:0]         inst;
    logic [`RV_XLEN-1:0] dataRData;
    logic [`RV_XLEN-1:0] instAddr;
    logic [`RV_XLEN-1:0] dataAddr;
    logic [`RV_XLEN-1:0] dataWData;
    logic                dataWrite;
    logic                dataRead;

    // Word-indexed memories of 1 KB each
    logic [31:0] rom  [256];
    logic [31:0] dmem [256];

    int          progLen;
    int          cycleCount = 0;
    logic [31:0] rngState = 32'h3232_2468;

    // Memory read cycles seen and expected in the current program
    int          loadCount;
    int          expLoads;

    // Stores the current program must leave behind
    int          expAddr [$];
    logic [31:0] expData [$];

    rvCore u_rvCore (
        .clk       (clk),
        .rstN      (rstN),
        .inst      (inst),
        .dataRData (dataRData),
        .instAddr  (instAddr),
        .dataAddr  (dataAddr),
        .dataWData (dataWData),
        .dataWrite (dataWrite),
        .dataRead  (dataRead)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // --------------------------------------------------
    // Memory models
    // --------------------------------------------------
    // Both return zero while in reset
    assign inst      = rstN ? rom[instAddr[9:2]] : 32'h0;
    assign dataRData = rstN ? dmem[dataAddr[9:2]] : '0;

    // Refilled during reset and written by stores on the clock edge
    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else if (dataWrite) begin
            dmem[dataAddr[9:2]] <= dataWData;
        end
    end

    // No store or read may leak out while reset is held
    // Out of reset every LW reads for exactly one cycle
    always @(negedge clk) begin
        if (!rstN) begin
            checkValue("dataWrite", 32'(dataWrite), 32'h0);
            checkValue("dataRead", 32'(dataRead), 32'h0);
        end else if (dataRead) begin
            loadCount++;
        end
    end

    // Cycle watchdog
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Verification failed");
            $fatal(1, "Timeout: the core did not reach the end of its program in %0d cycles",
                   CYCLE_LIMIT);
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    // Pattern built from the full word index
    function automatic logic [31:0] fillWord(input int idx);
        return {16'hF11E, 8'(idx), ~8'(idx)};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic nextRand(output logic [31:0] value);
        rngState = xorshift32(rngState);
        value = rngState;
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=0x%08h expected=0x%08h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    // Instruction encoders
    function automatic logic [31:0] rType(input int f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), f3, 5'(rd), rvIsaPkg::OPC_R};
    endfunction

    function automatic logic [31:0] iType(input logic [31:0] imm, input int rs1,
                                          input logic [2:0] f3, input int rd,
                                          input logic [6:0] opc);
        return {imm[11:0], 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] sType(input logic [31:0] imm, input int rs2, input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), rvIsaPkg::F3_LW_SW, imm[4:0], rvIsaPkg::OPC_S};
    endfunction

    function automatic logic [31:0] bType(input logic [31:0] imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], rvIsaPkg::OPC_B};
    endfunction

    // Upper 20 bits passed in the low end of u
    function automatic logic [31:0] uType(input logic [31:0] u, input int rd,
                                          input logic [6:0] opc);
        return {u[19:0], 5'(rd), opc};
    endfunction

    function automatic logic [31:0] jType(input logic [31:0] imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), rvIsaPkg::OPC_JAL};
    endfunction

    // --------------------------------------------------
    // Reference rules
    // --------------------------------------------------
    // k runs ADD SUB AND OR XOR SLL SRL SRA SLT SLTU
    function automatic logic [2:0] regOpF3(input int k);
        case (k)
            0, 1:    return rvIsaPkg::F3_ADD;
            2:       return rvIsaPkg::F3_AND;
            3:       return rvIsaPkg::F3_OR;
            4:       return rvIsaPkg::F3_XOR;
            5:       return rvIsaPkg::F3_SLL;
            6, 7:    return rvIsaPkg::F3_SR;
            8:       return rvIsaPkg::F3_SLT;
            default: return rvIsaPkg::F3_SLTU;
        endcase
    endfunction

    function automatic logic [31:0] regOpModel(input int k, input logic [31:0] a,
                                               input logic [31:0] b);
        case (k)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return a << b[4:0];
            6:       return a >> b[4:0];
            7:       return $signed(a) >>> b[4:0];
            8:       return {31'b0, $signed(a) < $signed(b)};
            default: return {31'b0, a < b};
        endcase
    endfunction

    // Kinds in order BEQ BNE BLT BGE BLTU BGEU
    function automatic logic [2:0] branchF3(input int kind);
        case (kind)
            0:       return rvIsaPkg::F3_BEQ;
            1:       return rvIsaPkg::F3_BNE;
            2:       return rvIsaPkg::F3_BLT;
            3:       return rvIsaPkg::F3_BGE;
            4:       return rvIsaPkg::F3_BLTU;
            default: return rvIsaPkg::F3_BGEU;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            rvIsaPkg::F3_BEQ:  return a == b;
            rvIsaPkg::F3_BNE:  return a != b;
            rvIsaPkg::F3_BLT:  return $signed(a) < $signed(b);
            rvIsaPkg::F3_BGE:  return $signed(a) >= $signed(b);
            rvIsaPkg::F3_BLTU: return a < b;
            default:           return a >= b;
        endcase
    endfunction

    // --------------------------------------------------
    // Program building and running
    // --------------------------------------------------
    // Byte address of the next instruction
    function automatic logic [31:0] here();
        return progLen * 4;
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[progLen] = word;
        progLen++;
    endtask

    // LUI + ADDI pair
    task automatic loadConst(input int rd, input logic [31:0] value);
        logic [31:0] upper;
        // Round up so the sign-extended low part lands on value
        upper = value + 32'h800;
        emit(uType({12'b0, upper[31:12]}, rd, rvIsaPkg::OPC_LUI));
        emit(iType(value, rd, rvIsaPkg::F3_ADD, rd, rvIsaPkg::OPC_I));
    endtask

    // SW rs, addr(x0) and the word it should leave
    task automatic storeWord(input int rs, input int addr, input logic [31:0] exp);
        emit(sType(addr, rs, 0));
        expAddr.push_back(addr);
        expData.push_back(exp);
    endtask

    // LW rd, offset(rs1) that the read count must see
    task automatic loadWord(input int rd, input int rs1, input logic [31:0] offset);
        emit(iType(offset, rs1, rvIsaPkg::F3_LW_SW, rd, rvIsaPkg::OPC_L));
        expLoads++;
    endtask

    // Hold the core in reset, then clear the ROM
    task automatic startProgram();
        @(posedge clk);
        #1;
        rstN = 1'b0;
        progLen = 0;
        loadCount = 0;
        expLoads = 0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = 32'h0;
        end
    endtask

    task automatic runProgram();
        logic [31:0] haltAddr;
        logic [31:0] data;
        int          addr;
        haltAddr = here();
        // Self-loop JAL x0, 0 ends the program
        emit(jType(0, 0));
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;
        // First fetch comes from the reset PC
        checkValue("instAddr", instAddr, `RV_RESET_PC);
        while (instAddr !== haltAddr) begin
            @(posedge clk);
            #1;
        end
        checkValue("dataRead", 32'(loadCount), 32'(expLoads));
        while (expAddr.size() > 0) begin
            addr = expAddr.pop_front();
            data = expData.pop_front();
            checkValue($sformatf("dmem[0x%03h]", addr), dmem[addr >> 2], data);
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic testRegOps();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        startProgram();
        // Negative a, positive b so SLT and SLTU disagree
        nextRand(r);
        a = r | 32'h8000_0000;
        nextRand(r);
        b = r & 32'h7FFF_FFFF;
        loadConst(1, a);
        loadConst(2, b);
        for (int k = 0; k < 10; k++) begin
            // SUB and SRA set funct7 bit 5
            emit(rType((k == 1 || k == 7) ? 32 : 0, 2, 1, regOpF3(k), 3));
            storeWord(3, 4 * k, regOpModel(k, a, b));
        end
        runProgram();
    endtask

    task automatic testImmOps();
        logic [31:0] a;
        logic [31:0] r;
        logic [31:0] imm;
        logic [31:0] u;
        logic [31:0] auipcPc;
        startProgram();
        nextRand(r);
        a = r | 32'h8000_0000;
        nextRand(r);
        // Sign-extended 12-bit immediate
        imm = {{20{r[11]}}, r[11:0]};
        nextRand(u);
        loadConst(1, a);
        emit(iType(imm, 1, rvIsaPkg::F3_ADD, 3, rvIsaPkg::OPC_I));
        storeWord(3, 'h100, regOpModel(0, a, imm));
        emit(iType(imm, 1, rvIsaPkg::F3_XOR, 3, rvIsaPkg::OPC_I));
        storeWord(3, 'h104, regOpModel(4, a, imm));
        emit(iType(imm, 1, rvIsaPkg::F3_SLT, 3, rvIsaPkg::OPC_I));
        storeWord(3, 'h108, regOpModel(8, a, imm));
        // Shift amount in imm[4:0] and SRAI also sets bit 30
        emit(iType({27'b0, imm[4:0]}, 1, rvIsaPkg::F3_SLL, 3, rvIsaPkg::OPC_I));
        storeWord(3, 'h10C, regOpModel(5, a, imm));
        emit(iType({20'b0, 7'b0100000, imm[4:0]}, 1, rvIsaPkg::F3_SR, 3, rvIsaPkg::OPC_I));
        storeWord(3, 'h110, regOpModel(7, a, imm));
        emit(uType(u, 3, rvIsaPkg::OPC_LUI));
        storeWord(3, 'h114, {u[19:0], 12'b0});
        // AUIPC adds to its own address
        auipcPc = here();
        emit(uType(u, 3, rvIsaPkg::OPC_AUIPC));
        storeWord(3, 'h118, auipcPc + {u[19:0], 12'b0});
        runProgram();
    endtask

    task automatic testLoadStore();
        logic [31:0] v1;
        logic [31:0] v2;
        startProgram();
        nextRand(v1);
        nextRand(v2);
        loadConst(1, v1);
        loadConst(2, v2);
        storeWord(1, 'h200, v1);
        storeWord(2, 'h204, v2);
        storeWord(1, 'h208, v1);
        // One load off x0 and one off a base register
        loadWord(4, 0, 'h200);
        emit(iType('h200, 0, rvIsaPkg::F3_ADD, 8, rvIsaPkg::OPC_I));
        loadWord(5, 8, 4);
        emit(rType(0, 5, 4, rvIsaPkg::F3_ADD, 6));
        storeWord(6, 'h20C, v1 + v2);
        // Untouched word still holds the fill pattern
        loadWord(7, 0, 'h220);
        storeWord(7, 'h224, fillWord('h220 >> 2));
        // x0 ignores an ALU write and a load
        emit(iType('h05A, 0, rvIsaPkg::F3_ADD, 0, rvIsaPkg::OPC_I));
        loadWord(0, 0, 'h200);
        storeWord(0, 'h210, 32'h0);
        runProgram();
    endtask

    task automatic testBranches();
        logic [31:0] r;
        logic [31:0] neg;
        logic [31:0] pos;
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        int          n;
        startProgram();
        nextRand(r);
        neg = r | 32'h8000_0000;
        nextRand(r);
        pos = r & 32'h7FFF_FFFF;
        n = 0;
        for (int kind = 0; kind < 6; kind++) begin
            f3 = branchF3(kind);
            // neg vs pos, equal, then pos vs neg
            for (int p = 0; p < 3; p++) begin
                a = (p == 0) ? neg : pos;
                b = (p == 2) ? neg : pos;
                loadConst(1, a);
                loadConst(2, b);
                // Taken skips the fall-through marker and its JAL
                emit(bType(12, 2, 1, f3));
                emit(iType(32'h200 + n, 0, rvIsaPkg::F3_ADD, 3, rvIsaPkg::OPC_I));
                emit(jType(8, 0));
                emit(iType(32'h400 + n, 0, rvIsaPkg::F3_ADD, 3, rvIsaPkg::OPC_I));
                storeWord(3, 'h300 + 4 * n,
                          branchTaken(f3, a, b) ? 32'h400 + n : 32'h200 + n);
                n++;
            end
        end
        runProgram();
    endtask

    task automatic testJumps();
        logic [31:0] jalLink;
        logic [31:0] jalrLink;
        logic [31:0] target;
        startProgram();
        jalLink = here() + 4;
        emit(jType(8, 1));
        emit(iType('h0DD, 0, rvIsaPkg::F3_ADD, 3, rvIsaPkg::OPC_I));
        emit(iType('h0A1, 0, rvIsaPkg::F3_ADD, 3, rvIsaPkg::OPC_I));
        storeWord(1, 'h380, jalLink);
        storeWord(3, 'h384, 32'h0A1);
        // JALR to x5+1 lands on x5 once bit 0 is cleared
        target = here() + 12;
        emit(iType(target, 0, rvIsaPkg::F3_ADD, 5, rvIsaPkg::OPC_I));
        jalrLink = here() + 4;
        emit(iType(1, 5, 3'b000, 2, rvIsaPkg::OPC_JALR));
        emit(iType('h0DE, 0, rvIsaPkg::F3_ADD, 3, rvIsaPkg::OPC_I));
        emit(iType('h0B2, 0, rvIsaPkg::F3_ADD, 3, rvIsaPkg::OPC_I));
        storeWord(2, 'h388, jalrLink);
        storeWord(3, 'h38C, 32'h0B2);
        runProgram();
    endtask

    // Registers left by the jump program must read zero
    task automatic testReset();
        startProgram();
        storeWord(3, 'h3C0, 32'h0);
        storeWord(2, 'h3C4, 32'h0);
        emit(iType('h055, 0, rvIsaPkg::F3_ADD, 1, rvIsaPkg::OPC_I));
        storeWord(1, 'h3C8, 32'h55);
        runProgram();
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        progLen = 0;
        testRegOps();
        testImmOps();
        testLoadStore();
        testBranches();
        testJumps();
        testReset();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* rvCore.f */
+incdir+include
design/rvIsaPkg.sv
design/rvCtrlPkg.sv
design/controller.sv
design/aluControl.sv
design/alu.sv
design/regFile.sv
design/immGen.sv
design/pcUnit.sv
design/rvCore.sv
dv/rvCoreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the rvCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

# Compile
if ! verilator --binary --timing -j 0 --top-module rvCoreTb --Mdir "$BUILD" -f rvCore.f; then
    echo "Verilator compile failed"
    exit 1
fi

# Run and keep the log
"./$BUILD/VrvCoreTb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Result
if grep -q "Verification failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
